// ==== source/btac_pkg.sv ====
package btac_pkg;
  timeunit 1ns;
  timeprecision 1ps;

  // address width of the core
  localparam int xlen = 32;

  // one pair of fetch addresses, looked up together every cycle
  typedef struct packed {
    logic [xlen-1:0] pc0;
    logic [xlen-1:0] pc1;
    logic stall;
    logic clear;
  } fetch_req_t;

  // one control-flow instruction as resolved in execute
  typedef struct packed {
    // instruction address
    logic [xlen-1:0] pc;
    // fall-through address, used as restart point for a wrongly taken branch
    logic [xlen-1:0] npc;
    // resolved target
    logic [xlen-1:0] addr;
    logic jal;
    logic branch;
    // set when the instruction really redirected the flow
    logic jump;
    // what fetch assumed for this instruction
    logic pred_taken;
    logic [xlen-1:0] pred_taddr;
  } resolve_slot_t;

  // both issue slots of the execute stage
  typedef struct packed {
    resolve_slot_t slot0;
    resolve_slot_t slot1;
    logic clear;
  } resolve_req_t;

  // answer to fetch
  typedef struct packed {
    // per-slot hit for the pair looked up in the previous cycle
    logic pred_branch0;
    logic pred_branch1;
    logic [xlen-1:0] pred_baddr;
    // restart address and flag, one cycle after the update
    logic [xlen-1:0] pred_maddr;
    logic pred_miss;
    // misprediction per slot, in the update cycle itself
    logic pred_hazard0;
    logic pred_hazard1;
  } prediction_t;

endpackage

// ==== source/target_buffer.sv ====
module target_buffer #(
  parameter int buffer_depth = 64
) (
  input logic clock,
  input logic wen,
  input logic [$clog2(buffer_depth)-1:0] waddr,
  input logic [$clog2(buffer_depth)-1:0] raddr0,
  input logic [$clog2(buffer_depth)-1:0] raddr1,
  input logic [btac_pkg::xlen-$clog2(buffer_depth)-2+btac_pkg::xlen-1:0] wdata,
  output logic [btac_pkg::xlen-$clog2(buffer_depth)-2+btac_pkg::xlen-1:0] rdata0,
  output logic [btac_pkg::xlen-$clog2(buffer_depth)-2+btac_pkg::xlen-1:0] rdata1
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int index_width = $clog2(buffer_depth);
  localparam int tag_width = btac_pkg::xlen - index_width - 2;
  localparam int entry_width = tag_width + btac_pkg::xlen;

  // an all-zero entry is read as empty
  logic [entry_width-1:0] entries [buffer_depth] = '{default: '0};

  logic [index_width-1:0] raddr0_q = '0;
  logic [index_width-1:0] raddr1_q = '0;

  // the write and the index capture share the edge, so a read right after it sees new data
  always_ff @(posedge clock) begin
    raddr0_q <= raddr0;
    raddr1_q <= raddr1;
    if (wen) begin
      entries[waddr] <= wdata;
    end
  end

  assign rdata0 = entries[raddr0_q];
  assign rdata1 = entries[raddr1_q];

  write_index_known: assert property (
    @(posedge clock) wen |-> !$isunknown(waddr)
  );

endmodule

// ==== source/btac_lookup.sv ====
module btac_lookup #(
  parameter int buffer_depth = 64
) (
  input logic clock,
  input logic reset,
  input btac_pkg::fetch_req_t fetch,
  input logic [btac_pkg::xlen-$clog2(buffer_depth)-2+btac_pkg::xlen-1:0] rdata0,
  input logic [btac_pkg::xlen-$clog2(buffer_depth)-2+btac_pkg::xlen-1:0] rdata1,
  output logic [$clog2(buffer_depth)-1:0] raddr0,
  output logic [$clog2(buffer_depth)-1:0] raddr1,
  output logic pred_branch0,
  output logic pred_branch1,
  output logic [btac_pkg::xlen-1:0] pred_baddr
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int xlen = btac_pkg::xlen;
  localparam int index_width = $clog2(buffer_depth);
  localparam int tag_width = xlen - index_width - 2;
  localparam int entry_width = tag_width + xlen;

  logic [xlen-1:0] pc0_q;
  logic [xlen-1:0] pc1_q;
  logic hit0;
  logic hit1;
  logic gated;

  // pcs of the pair the buffer is answering this cycle
  always_ff @(posedge clock) begin
    if (!reset) begin
      pc0_q <= '0;
      pc1_q <= '0;
    end else if (!fetch.clear) begin
      pc0_q <= fetch.pc0;
      pc1_q <= fetch.pc1;
    end
  end

  // on clear the buffer keeps pointing at the held pair
  always_comb begin
    if (fetch.clear) begin
      raddr0 = pc0_q[index_width+1:2];
      raddr1 = pc1_q[index_width+1:2];
    end else begin
      raddr0 = fetch.pc0[index_width+1:2];
      raddr1 = fetch.pc1[index_width+1:2];
    end
  end

  assign hit0 = (|rdata0) && (rdata0[entry_width-1:xlen] == pc0_q[xlen-1:index_width+2]);
  assign hit1 = (|rdata1) && (rdata1[entry_width-1:xlen] == pc1_q[xlen-1:index_width+2]);

  assign gated = fetch.stall | fetch.clear;

  always_comb begin
    pred_branch0 = 1'b0;
    pred_branch1 = 1'b0;
    pred_baddr = '0;
    if (!gated) begin
      pred_branch0 = hit0;
      pred_branch1 = hit1;
      // slot 0 wins when both slots hit
      pred_baddr = hit0 ? rdata0[xlen-1:0] : rdata1[xlen-1:0];
    end
  end

  stall_silences_prediction: assert property (
    @(posedge clock) disable iff (!reset)
    fetch.stall |-> !pred_branch0 && !pred_branch1 && pred_baddr == '0
  );

endmodule

// ==== source/btac_resolve.sv ====
module btac_resolve #(
  parameter int buffer_depth = 64
) (
  input logic clock,
  input logic reset,
  input btac_pkg::resolve_req_t resolve,
  output logic wen,
  output logic [$clog2(buffer_depth)-1:0] waddr,
  output logic [btac_pkg::xlen-$clog2(buffer_depth)-2+btac_pkg::xlen-1:0] wdata,
  output logic [btac_pkg::xlen-1:0] pred_maddr,
  output logic pred_miss,
  output logic pred_hazard0,
  output logic pred_hazard1
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int xlen = btac_pkg::xlen;
  localparam int index_width = $clog2(buffer_depth);

  typedef struct packed {
    logic miss;
    logic [xlen-1:0] maddr;
  } outcome_t;

  // outcome of a slot that fetch had predicted taken
  function automatic outcome_t check_predicted(input btac_pkg::resolve_slot_t slot);
    outcome_t result;
    result = '0;
    if (slot.jump) begin
      result.miss = slot.addr != slot.pred_taddr;
      result.maddr = slot.addr;
    end else if (slot.branch) begin
      result.miss = 1'b1;
      result.maddr = slot.npc;
    end
    return result;
  endfunction

  logic write0;
  logic write1;
  logic miss0;
  logic miss1;
  logic [xlen-1:0] maddr;
  logic [xlen-1:0] maddr_q;
  logic miss_q;
  outcome_t outcome0;
  outcome_t outcome1;

  assign write0 = (resolve.slot0.jal | resolve.slot0.branch) & resolve.slot0.jump;
  assign write1 = (resolve.slot1.jal | resolve.slot1.branch) & resolve.slot1.jump;

  always_comb begin
    wen = 1'b0;
    waddr = '0;
    wdata = '0;
    if (!resolve.clear) begin
      wen = write0 | write1;
      if (write0) begin
        waddr = resolve.slot0.pc[index_width+1:2];
        wdata = {resolve.slot0.pc[xlen-1:index_width+2], resolve.slot0.addr};
      end else begin
        waddr = resolve.slot1.pc[index_width+1:2];
        wdata = {resolve.slot1.pc[xlen-1:index_width+2], resolve.slot1.addr};
      end
    end
  end

  assign outcome0 = check_predicted(resolve.slot0);
  assign outcome1 = check_predicted(resolve.slot1);

  always_comb begin
    miss0 = 1'b0;
    miss1 = 1'b0;
    maddr = '0;
    if (resolve.clear) begin
      maddr = '0;
    end else if (resolve.slot0.pred_taken) begin
      miss0 = outcome0.miss;
      maddr = outcome0.maddr;
    end else if (resolve.slot1.pred_taken) begin
      miss1 = outcome1.miss;
      maddr = outcome1.maddr;
    end else if (resolve.slot0.jump) begin
      // nothing predicted, so the first taken slot redirects fetch
      miss0 = 1'b1;
      maddr = resolve.slot0.addr;
    end else if (resolve.slot1.jump) begin
      miss1 = 1'b1;
      maddr = resolve.slot1.addr;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      maddr_q <= '0;
      miss_q <= 1'b0;
    end else begin
      maddr_q <= maddr;
      miss_q <= miss0 | miss1;
    end
  end

  assign pred_maddr = maddr_q;
  assign pred_miss = miss_q;
  assign pred_hazard0 = miss0;
  assign pred_hazard1 = miss1;

  clear_blocks_update: assert property (
    @(posedge clock) disable iff (!reset)
    resolve.clear |-> !wen ##1 !pred_miss
  );

endmodule

// ==== source/btac.sv ====
module btac #(
  parameter int buffer_depth = 64
) (
  input logic clock,
  input logic reset,
  input btac_pkg::fetch_req_t fetch,
  input btac_pkg::resolve_req_t resolve,
  output btac_pkg::prediction_t prediction
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int xlen = btac_pkg::xlen;
  localparam int index_width = $clog2(buffer_depth);
  localparam int entry_width = xlen - index_width - 2 + xlen;

  logic [index_width-1:0] raddr0;
  logic [index_width-1:0] raddr1;
  logic [index_width-1:0] waddr;
  logic [entry_width-1:0] rdata0;
  logic [entry_width-1:0] rdata1;
  logic [entry_width-1:0] wdata;
  logic wen;
  logic branch0;
  logic branch1;
  logic [xlen-1:0] baddr;
  logic [xlen-1:0] maddr;
  logic miss;
  logic hazard0;
  logic hazard1;

  target_buffer #(.buffer_depth(buffer_depth)) buffer0 (
    .clock(clock), .wen(wen), .waddr(waddr), .raddr0(raddr0), .raddr1(raddr1),
    .wdata(wdata), .rdata0(rdata0), .rdata1(rdata1)
  );

  btac_lookup #(.buffer_depth(buffer_depth)) lookup0 (
    .clock(clock), .reset(reset), .fetch(fetch), .rdata0(rdata0), .rdata1(rdata1),
    .raddr0(raddr0), .raddr1(raddr1), .pred_branch0(branch0), .pred_branch1(branch1),
    .pred_baddr(baddr)
  );

  btac_resolve #(.buffer_depth(buffer_depth)) resolve0 (
    .clock(clock), .reset(reset), .resolve(resolve), .wen(wen), .waddr(waddr),
    .wdata(wdata), .pred_maddr(maddr), .pred_miss(miss), .pred_hazard0(hazard0),
    .pred_hazard1(hazard1)
  );

  assign prediction = '{
    pred_branch0: branch0,
    pred_branch1: branch1,
    pred_baddr: baddr,
    pred_maddr: maddr,
    pred_miss: miss,
    pred_hazard0: hazard0,
    pred_hazard1: hazard1
  };

endmodule

// ==== dv/btac_tb.sv ====
module btac_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int xlen = btac_pkg::xlen;
  localparam int buffer_depth = 64;
  localparam int index_width = $clog2(buffer_depth);
  localparam int tag_width = xlen - index_width - 2;
  localparam int entry_width = tag_width + xlen;
  // the sequence needs about 50 cycles
  localparam int cycle_limit = 2000;

  logic clock;
  logic reset;
  btac_pkg::fetch_req_t fetch;
  btac_pkg::resolve_req_t resolve;
  btac_pkg::prediction_t prediction;

  int seed = 32'h828b;
  int error_count = 0;
  int test_count = 0;
  int errors_at_start = 0;
  int cycle_count = 0;
  string test_name = "reset";

  // reference copy of the buffer that holds only the indexes that were written
  logic [entry_width-1:0] model [int];
  logic [xlen-1:0] held_pc0 = '0;
  logic [xlen-1:0] held_pc1 = '0;
  logic exp_branch0 = 1'b0;
  logic exp_branch1 = 1'b0;
  logic [xlen-1:0] exp_baddr = '0;
  logic exp_hazard0;
  logic exp_hazard1;
  logic exp_miss;
  logic [xlen-1:0] exp_maddr;
  logic exp_miss_q = 1'b0;
  logic [xlen-1:0] exp_maddr_q = '0;
  logic gated;

  btac dut0 (
    .clock(clock), .reset(reset), .fetch(fetch), .resolve(resolve), .prediction(prediction)
  );

  function automatic logic [index_width-1:0] index_of(input logic [xlen-1:0] pc);
    return pc[index_width+1:2];
  endfunction

  function automatic logic [tag_width-1:0] tag_of(input logic [xlen-1:0] pc);
    return pc[xlen-1:index_width+2];
  endfunction

  function automatic logic [entry_width-1:0] stored_entry(input logic [index_width-1:0] idx);
    return model.exists(int'(idx)) ? model[int'(idx)] : '0;
  endfunction

  function automatic logic takes_entry(input btac_pkg::resolve_slot_t slot);
    return slot.jump && (slot.jal || slot.branch);
  endfunction

  // a predicted-taken slot is wrong if it went elsewhere or fell through as a branch
  function automatic logic wrong_guess(input btac_pkg::resolve_slot_t slot);
    return slot.jump ? slot.addr != slot.pred_taddr : slot.branch;
  endfunction

  function automatic logic [xlen-1:0] restart_of(input btac_pkg::resolve_slot_t slot);
    return slot.jump ? slot.addr : slot.npc;
  endfunction

  function automatic btac_pkg::resolve_slot_t make_slot(
    input logic [xlen-1:0] pc, input logic [xlen-1:0] addr, input logic jal,
    input logic branch, input logic jump, input logic pred_taken,
    input logic [xlen-1:0] pred_taddr
  );
    return '{pc: pc, npc: pc + 4, addr: addr, jal: jal, branch: branch, jump: jump,
             pred_taken: pred_taken, pred_taddr: pred_taddr};
  endfunction

  function automatic btac_pkg::fetch_req_t lookup_of(
    input logic [xlen-1:0] pc0, input logic [xlen-1:0] pc1, input logic stall, input logic clear
  );
    return '{pc0: pc0, pc1: pc1, stall: stall, clear: clear};
  endfunction

  function automatic btac_pkg::resolve_req_t update_of(
    input btac_pkg::resolve_slot_t slot0, input btac_pkg::resolve_slot_t slot1, input logic clear
  );
    return '{slot0: slot0, slot1: slot1, clear: clear};
  endfunction

  function logic [xlen-1:0] random_pc();
    return $random(seed) & ~32'd3;
  endfunction

  task automatic drive(input btac_pkg::fetch_req_t f, input btac_pkg::resolve_req_t r);
    @(posedge clock);
    fetch <= f;
    resolve <= r;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    errors_at_start = error_count;
  endtask

  task automatic end_test();
    repeat (2) drive('0, '0);
    test_count++;
    $display("test %s finished with %0d failed checks", test_name, error_count - errors_at_start);
  endtask

  task automatic report_value(input string what, input logic [xlen-1:0] expected,
                              input logic [xlen-1:0] actual);
    $display("CHECK FAILED %s %s expected %h actual %h", test_name, what, expected, actual);
    error_count++;
  endtask

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout, the tests did not finish within %0d cycles", cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

  // a write of this cycle is visible to the pair sampled on the same edge
  always @(posedge clock) begin
    btac_pkg::resolve_slot_t winner;
    logic [entry_width-1:0] entry0;
    logic [entry_width-1:0] entry1;
    logic hit0;
    logic hit1;
    if (!resolve.clear && (takes_entry(resolve.slot0) || takes_entry(resolve.slot1))) begin
      winner = takes_entry(resolve.slot0) ? resolve.slot0 : resolve.slot1;
      model[int'(index_of(winner.pc))] = {tag_of(winner.pc), winner.addr};
    end
    if (!reset) begin
      held_pc0 = '0;
      held_pc1 = '0;
    end else if (!fetch.clear) begin
      held_pc0 = fetch.pc0;
      held_pc1 = fetch.pc1;
    end
    entry0 = stored_entry(index_of(held_pc0));
    entry1 = stored_entry(index_of(held_pc1));
    hit0 = (entry0 != '0) && (entry0[entry_width-1:xlen] == tag_of(held_pc0));
    hit1 = (entry1 != '0) && (entry1[entry_width-1:xlen] == tag_of(held_pc1));
    exp_branch0 <= hit0;
    exp_branch1 <= hit1;
    exp_baddr <= hit0 ? entry0[xlen-1:0] : entry1[xlen-1:0];
    if (!reset) begin
      exp_miss_q <= 1'b0;
      exp_maddr_q <= '0;
    end else begin
      exp_miss_q <= exp_miss;
      exp_maddr_q <= exp_maddr;
    end
  end

  always_comb begin
    exp_hazard0 = 1'b0;
    exp_hazard1 = 1'b0;
    exp_maddr = '0;
    if (!resolve.clear) begin
      if (resolve.slot0.pred_taken) begin
        exp_hazard0 = wrong_guess(resolve.slot0);
        exp_maddr = restart_of(resolve.slot0);
      end else if (resolve.slot1.pred_taken) begin
        exp_hazard1 = wrong_guess(resolve.slot1);
        exp_maddr = restart_of(resolve.slot1);
      end else if (resolve.slot0.jump) begin
        exp_hazard0 = 1'b1;
        exp_maddr = resolve.slot0.addr;
      end else if (resolve.slot1.jump) begin
        exp_hazard1 = 1'b1;
        exp_maddr = resolve.slot1.addr;
      end
    end
  end

  assign exp_miss = exp_hazard0 | exp_hazard1;
  assign gated = fetch.stall | fetch.clear;

  branch0_matches: assert property (@(posedge clock) disable iff (!reset)
    prediction.pred_branch0 == (exp_branch0 && !gated)
  ) else report_value("pred_branch0", exp_branch0 && !gated, prediction.pred_branch0);

  branch1_matches: assert property (@(posedge clock) disable iff (!reset)
    prediction.pred_branch1 == (exp_branch1 && !gated)
  ) else report_value("pred_branch1", exp_branch1 && !gated, prediction.pred_branch1);

  baddr_matches: assert property (@(posedge clock) disable iff (!reset)
    prediction.pred_baddr == (gated ? '0 : exp_baddr)
  ) else report_value("pred_baddr", gated ? '0 : exp_baddr, prediction.pred_baddr);

  hazard0_matches: assert property (@(posedge clock) disable iff (!reset)
    prediction.pred_hazard0 == exp_hazard0
  ) else report_value("pred_hazard0", exp_hazard0, prediction.pred_hazard0);

  hazard1_matches: assert property (@(posedge clock) disable iff (!reset)
    prediction.pred_hazard1 == exp_hazard1
  ) else report_value("pred_hazard1", exp_hazard1, prediction.pred_hazard1);

  miss_matches: assert property (@(posedge clock) disable iff (!reset)
    prediction.pred_miss == exp_miss_q
  ) else report_value("pred_miss", exp_miss_q, prediction.pred_miss);

  maddr_matches: assert property (@(posedge clock) disable iff (!reset)
    exp_miss_q |-> prediction.pred_maddr == exp_maddr_q
  ) else report_value("pred_maddr", exp_maddr_q, prediction.pred_maddr);

  restart_idle_after_reset: assert property (@(posedge clock)
    $rose(reset) |-> !prediction.pred_miss && prediction.pred_maddr == '0
  ) else begin
    $display("restart outputs were not zero when reset was released");
    error_count++;
  end

  initial begin
    logic [xlen-1:0] pc_a;
    logic [xlen-1:0] pc_b;
    logic [xlen-1:0] target_a;
    logic [xlen-1:0] target_b;
    reset = 1'b0;
    fetch = '0;
    // a mispredicted branch is pending through reset but must not reach the restart outputs
    resolve = update_of(make_slot(32'h100, 32'h200, 1'b0, 1'b1, 1'b0, 1'b1, 32'h200), '0,
                        1'b0);
    repeat (4) @(posedge clock);
    reset <= 1'b1;
    resolve <= '0;
    @(posedge clock);

    begin_test("cold_lookup");
    repeat (8) drive(lookup_of(random_pc(), random_pc(), 1'b0, 1'b0), '0);
    end_test();

    begin_test("install_and_hit");
    pc_a = random_pc();
    pc_b = pc_a + 4;
    target_a = random_pc();
    target_b = random_pc();
    drive('0, update_of(make_slot(pc_a, target_a, 1'b1, 1'b0, 1'b1, 1'b0, '0), '0, 1'b0));
    // pc_b is looked up on the edge that commits its slot-1 write
    drive(lookup_of(pc_a, pc_b, 1'b0, 1'b0),
          update_of('0, make_slot(pc_b, target_b, 1'b0, 1'b1, 1'b1, 1'b0, '0), 1'b0));
    drive(lookup_of(pc_a, pc_a, 1'b0, 1'b0), '0);
    drive(lookup_of(pc_a + 8, pc_b, 1'b0, 1'b0), '0);
    end_test();

    begin_test("aliasing");
    drive(lookup_of(pc_a ^ (32'd1 << (index_width + 2)), pc_b ^ 32'h8000_0000, 1'b0, 1'b0), '0);
    drive(lookup_of(pc_a, pc_b ^ 32'h0010_0000, 1'b0, 1'b0), '0);
    end_test();

    begin_test("misprediction");
    pc_a = random_pc();
    target_a = random_pc();
    drive('0, update_of(make_slot(pc_a, target_a, 1'b0, 1'b1, 1'b1, 1'b1, target_a), '0, 1'b0));
    drive('0, '0);
    drive('0, update_of(make_slot(pc_a, target_a, 1'b0, 1'b1, 1'b1, 1'b1, target_a + 16), '0,
                        1'b0));
    drive('0, '0);
    drive('0, update_of(make_slot(pc_a, target_a, 1'b0, 1'b1, 1'b0, 1'b1, target_a), '0, 1'b0));
    drive('0, '0);
    drive('0, update_of(make_slot(pc_a, target_a, 1'b0, 1'b1, 1'b0, 1'b0, '0),
                        make_slot(pc_a + 4, target_b, 1'b1, 1'b0, 1'b1, 1'b0, '0), 1'b0));
    drive('0, '0);
    drive('0, update_of(make_slot(pc_a, target_a, 1'b0, 1'b1, 1'b0, 1'b0, '0),
                        make_slot(pc_a + 4, target_b, 1'b0, 1'b1, 1'b1, 1'b1, target_a), 1'b0));
    end_test();

    begin_test("stall_and_clear");
    pc_a = random_pc();
    target_a = random_pc();
    drive('0, update_of(make_slot(pc_a, target_a, 1'b1, 1'b0, 1'b1, 1'b0, '0), '0, 1'b0));
    drive(lookup_of(pc_a, pc_a, 1'b0, 1'b0), '0);
    drive(lookup_of(random_pc(), random_pc(), 1'b1, 1'b0), '0);
    drive(lookup_of(pc_a, pc_a, 1'b0, 1'b0), '0);
    // clear keeps pc_a in the lookup stage, so the cycle after it still hits
    drive(lookup_of(random_pc(), random_pc(), 1'b0, 1'b1), '0);
    drive('0, '0);
    pc_b = random_pc();
    drive('0, update_of(make_slot(pc_b, target_b, 1'b1, 1'b0, 1'b1, 1'b0, '0), '0, 1'b1));
    drive('0, '0);
    drive(lookup_of(pc_b, pc_b, 1'b0, 1'b0), '0);
    end_test();

    $display("%0d tests run, %0d failed checks", test_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
source/btac_pkg.sv
source/target_buffer.sv
source/btac_lookup.sv
source/btac_resolve.sv
source/btac.sv
dv/btac_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= btac_tb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert
PASS_TEXT ?= No errors

SOURCES := $(wildcard source/*.sv) $(wildcard dv/*.sv)
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
